/* Makefile */
# verilator build and run of the pool datapath testbench
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_pool_datapath: sim.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -f sim.f \
		--top-module tb_pool_datapath -Mdir obj_dir

run: obj_dir/Vtb_pool_datapath
	-./obj_dir/Vtb_pool_datapath > sim.log 2>&1
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim.f */
src/pool_pkg.sv
src/adc_sipo.sv
src/uart_rx.sv
src/peak_hold.sv
src/report_sequencer.sv
src/uart_tx.sv
src/pool_datapath.sv
test/tb_pool_datapath.sv

/* src/adc_sipo.sv */
// serial-in parallel-out shifter for the adc bit stream
`timescale 1ns/100ps

module adc_sipo (
    input  logic                clk,
    input  logic                reset,
    input  logic                adc_in,
    input  logic                adc_bit_valid,
    input  logic                data_logging,
    input  logic                data_ready,
    output pool_pkg::adc_word_s sample
);

    // shift register where the msb arrives first
    pool_pkg::adc_sample_t shift_reg;
    logic                  sample_valid;
    pool_pkg::adc_sample_t sample_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (adc_bit_valid && data_logging) begin
            // bits seen with logging off are simply skipped
            shift_reg <= {shift_reg[pool_pkg::SAMPLE_W-2:0], adc_in};
        end
    end

    // publish the register one cycle after data_ready
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= data_ready;
        end
        if (data_ready) begin
            sample_value <= shift_reg;
        end
    end

    assign sample = '{valid: sample_valid, value: sample_value};

endmodule

/* src/peak_hold.sv */
// running maximum with windowed clear and transmit snapshot
`timescale 1ns/100ps

module peak_hold (
    input  logic                  clk,
    input  logic                  reset,
    input  pool_pkg::adc_word_s   sample,
    input  logic                  txing,
    output pool_pkg::adc_sample_t snapshot
);

    logic [pool_pkg::TICK_CNT_W-1:0]   tick_cnt;
    logic [pool_pkg::WINDOW_CNT_W-1:0] window_cnt;
    pool_pkg::adc_sample_t             peak;
    logic                              tick;
    logic                              window_end;

    // eighth-second strobe
    assign tick = (tick_cnt == pool_pkg::TICK_CNT_W'(pool_pkg::TICK_CYCLES - 1));
    assign window_end = (window_cnt == pool_pkg::WINDOW_CNT_W'(pool_pkg::WINDOW_TICKS));

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt   <= '0;
            window_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            // window count restarts once the clear has happened
            if (window_end) begin
                window_cnt <= '0;
            end else if (tick) begin
                window_cnt <= window_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peak     <= '0;
            snapshot <= '0;
        end else begin
            // clear wins over a sample in the same cycle
            if (window_end) begin
                peak <= '0;
            end else if (sample.valid && sample.value > peak) begin
                peak <= sample.value;
            end
            // freeze while a report is going out so its bytes match
            if (!txing) begin
                snapshot <= peak;
            end
        end
    end

endmodule

/* src/pool_datapath.sv */
// top level tying adc input, peak hold and uart report path together
`timescale 1ns/100ps

module pool_datapath (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 adc_in,
    input  logic                 adc_bit_valid,
    input  logic                 data_logging,
    input  logic                 data_ready,
    input  logic                 rx,
    output logic                 tx,
    output pool_pkg::uart_byte_s rx_byte,
    output logic                 txing
);

    pool_pkg::adc_word_s   sample;
    pool_pkg::adc_sample_t snapshot;
    pool_pkg::uart_byte_s  tx_req;
    logic                  tx_ready;

    // input side
    adc_sipo u_adc_sipo (
        .clk           (clk),
        .reset         (reset),
        .adc_in        (adc_in),
        .adc_bit_valid (adc_bit_valid),
        .data_logging  (data_logging),
        .data_ready    (data_ready),
        .sample        (sample)
    );

    uart_rx u_uart_rx (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    peak_hold u_peak_hold (
        .clk      (clk),
        .reset    (reset),
        .sample   (sample),
        .txing    (txing),
        .snapshot (snapshot)
    );

    // output side
    report_sequencer u_report_sequencer (
        .clk      (clk),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .snapshot (snapshot),
        .tx_ready (tx_ready),
        .txing    (txing),
        .tx_req   (tx_req)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_req   (tx_req),
        .tx       (tx),
        .tx_ready (tx_ready)
    );

endmodule

/* src/pool_pkg.sv */
// shared sizes, timing constants, enums and packed structs for the pool datapath
package pool_pkg;

    // data widths
    localparam int SAMPLE_W = 10;
    localparam int BYTE_W   = 8;

    // clocks per uart bit and bits per 8N1 frame
    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_BITS   = 10;

    // eighth-second tick scaled down so a window fits in simulation
    localparam int TICK_CYCLES  = 32;
    // 40 ticks make the 5 s peak window
    localparam int WINDOW_TICKS = 40;

    // counter widths derived from the timing constants
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int BIT_CNT_W    = $clog2(FRAME_BITS);
    localparam int TICK_CNT_W   = $clog2(TICK_CYCLES);
    localparam int WINDOW_CNT_W = $clog2(WINDOW_TICKS + 1);

    // report protocol bytes
    localparam logic [7:0] TAG_BYTE    = 8'h41;
    localparam logic [7:0] CMD_REPORT  = 8'h52;
    localparam logic [2:0] WORD_PREFIX = 3'b100;

    typedef logic [SAMPLE_W-1:0] adc_sample_t;
    typedef logic [BYTE_W-1:0]   uart_byte_t;

    // one adc sample with its strobe
    typedef struct packed {
        logic        valid;
        adc_sample_t value;
    } adc_word_s;

    // one uart byte with its strobe, used on both rx and tx sides
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } uart_byte_s;

    typedef enum logic [1:0] {
        idle,
        send_tag,
        send_low,
        send_high
    } report_state_e;

    typedef enum logic [1:0] {
        idle_word,
        tag_word,
        low_word,
        high_word
    } word_sel_e;

endpackage

/* src/report_sequencer.sv */
// report command decode and tag/low/high byte formatting
`timescale 1ns/100ps

module report_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  pool_pkg::uart_byte_s  rx_byte,
    input  pool_pkg::adc_sample_t snapshot,
    input  logic                  tx_ready,
    output logic                  txing,
    output pool_pkg::uart_byte_s  tx_req
);

    pool_pkg::report_state_e state;
    pool_pkg::report_state_e state_next;
    pool_pkg::word_sel_e     word_sel;
    pool_pkg::uart_byte_t    word_to_send;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pool_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // each send state moves on once uart_tx takes its byte
    always_comb begin
        state_next = state;
        case (state)
            pool_pkg::idle: begin
                // only the report command starts a run
                if (rx_byte.valid && rx_byte.data == pool_pkg::CMD_REPORT) begin
                    state_next = pool_pkg::send_tag;
                end
            end
            pool_pkg::send_tag: if (tx_ready) state_next = pool_pkg::send_low;
            pool_pkg::send_low: if (tx_ready) state_next = pool_pkg::send_high;
            pool_pkg::send_high: if (tx_ready) state_next = pool_pkg::idle;
            default: state_next = pool_pkg::idle;
        endcase
    end

    always_comb begin
        case (state)
            pool_pkg::send_tag:  word_sel = pool_pkg::tag_word;
            pool_pkg::send_low:  word_sel = pool_pkg::low_word;
            pool_pkg::send_high: word_sel = pool_pkg::high_word;
            default:             word_sel = pool_pkg::idle_word;
        endcase
    end

    // data bytes carry five sample bits under the prefix
    always_comb begin
        case (word_sel)
            pool_pkg::tag_word:  word_to_send = pool_pkg::TAG_BYTE;
            pool_pkg::low_word:  word_to_send = {pool_pkg::WORD_PREFIX, snapshot[4:0]};
            pool_pkg::high_word: word_to_send = {pool_pkg::WORD_PREFIX, snapshot[9:5]};
            default:             word_to_send = '0;
        endcase
    end

    assign txing  = (state != pool_pkg::idle);
    assign tx_req = '{valid: txing && tx_ready, data: word_to_send};

endmodule

/* src/uart_rx.sv */
// 8N1 uart receiver with input synchronizer and mid-bit sampling
`timescale 1ns/100ps

module uart_rx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx,
    output pool_pkg::uart_byte_s rx_byte
);

    // two-flop synchronizer plus one more stage for edge detect
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic                              busy;
    logic [pool_pkg::BAUD_CNT_W-1:0]   baud_cnt;
    // 0 is the start bit, 1..8 data, last is the stop bit
    logic [pool_pkg::BIT_CNT_W-1:0]    bit_cnt;
    pool_pkg::uart_byte_t              shift_reg;
    logic                              byte_valid;

    logic start_edge;
    logic mid_bit;
    logic end_bit;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;
    assign mid_bit = (baud_cnt == pool_pkg::BAUD_CNT_W'(pool_pkg::CLKS_PER_BIT / 2));
    assign end_bit = (baud_cnt == pool_pkg::BAUD_CNT_W'(pool_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy) begin
                if (start_edge) begin
                    busy     <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else begin
                baud_cnt <= end_bit ? '0 : baud_cnt + 1'b1;
                if (end_bit) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (mid_bit) begin
                    if (bit_cnt == '0) begin
                        // line back high means a glitch rather than a start bit
                        if (rx_sync) begin
                            busy <= 1'b0;
                        end
                    end else if (bit_cnt == pool_pkg::BIT_CNT_W'(pool_pkg::FRAME_BITS - 1)) begin
                        // bad framing at the stop bit drops the byte
                        busy       <= 1'b0;
                        byte_valid <= rx_sync;
                    end
                end
            end
        end
    end

    // data bits come lsb first so they shift in from the top
    always_ff @(posedge clk) begin
        if (busy && mid_bit && bit_cnt != '0
                && bit_cnt != pool_pkg::BIT_CNT_W'(pool_pkg::FRAME_BITS - 1)) begin
            shift_reg <= {rx_sync, shift_reg[pool_pkg::BYTE_W-1:1]};
        end
    end

    assign rx_byte = '{valid: byte_valid, data: shift_reg};

endmodule

/* src/uart_tx.sv */
// 8N1 uart transmitter with ready level
`timescale 1ns/100ps

module uart_tx (
    input  logic                 clk,
    input  logic                 reset,
    input  pool_pkg::uart_byte_s tx_req,
    output logic                 tx,
    output logic                 tx_ready
);

    logic                            busy;
    logic [pool_pkg::BAUD_CNT_W-1:0] baud_cnt;
    logic [pool_pkg::BIT_CNT_W-1:0]  bit_cnt;
    // stop, data and start bits with the start bit in bit 0
    logic [pool_pkg::FRAME_BITS-1:0] frame;
    logic                            end_bit;

    assign end_bit = (baud_cnt == pool_pkg::BAUD_CNT_W'(pool_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (tx_req.valid) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            baud_cnt <= end_bit ? '0 : baud_cnt + 1'b1;
            if (end_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                // ready again once the stop bit has run its full time
                if (bit_cnt == pool_pkg::BIT_CNT_W'(pool_pkg::FRAME_BITS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // frame shifter refills with ones so the line rests high
    always_ff @(posedge clk) begin
        if (!busy && tx_req.valid) begin
            frame <= {1'b1, tx_req.data, 1'b0};
        end else if (busy && end_bit) begin
            frame <= {1'b1, frame[pool_pkg::FRAME_BITS-1:1]};
        end
    end

    assign tx       = busy ? frame[0] : 1'b1;
    assign tx_ready = !busy;

endmodule

/* test/tb_pool_datapath.sv */
// testbench for pool_datapath with step table, uart line models, peak scoreboard and compare tasks
`timescale 1ns/100ps

module tb_pool_datapath;

    // one uart frame and one peak window, in clocks
    localparam int FRAME_CYCLES  = pool_pkg::FRAME_BITS * pool_pkg::CLKS_PER_BIT;
    localparam int WINDOW_CYCLES = pool_pkg::WINDOW_TICKS * pool_pkg::TICK_CYCLES;
    localparam logic [15:0] CMD_R = {8'h00, pool_pkg::CMD_REPORT};
    localparam pool_pkg::adc_sample_t ALL_BITS = '1;

    typedef enum logic [1:0] {
        op_shift,
        op_send,
        op_wait,
        op_sync
    } step_op_e;

    // one table row, arg holds a sample, a byte or a cycle count
    typedef struct packed {
        step_op_e              op;
        logic                  rnd;
        logic [15:0]           arg;
        pool_pkg::adc_sample_t mask;
        logic                  report;
    } step_s;

    logic                 clk;
    logic                 reset;
    logic                 adc_in;
    logic                 adc_bit_valid;
    logic                 data_logging;
    logic                 data_ready;
    logic                 rx;
    logic                 tx;
    pool_pkg::uart_byte_s rx_byte;
    logic                 txing;

    step_s                 steps[$];
    // tx bytes still owed by accepted reports
    pool_pkg::uart_byte_t  exp_q[$];
    pool_pkg::uart_byte_s  rx_q[$];
    // scoreboard state
    pool_pkg::adc_sample_t model_peak;
    pool_pkg::adc_sample_t model_shift;
    integer                seed;
    int                    run_cycles;
    int                    timeout_limit;

    pool_datapath u_dut (
        .clk           (clk),
        .reset         (reset),
        .adc_in        (adc_in),
        .adc_bit_valid (adc_bit_valid),
        .data_logging  (data_logging),
        .data_ready    (data_ready),
        .rx            (rx),
        .tx            (tx),
        .rx_byte       (rx_byte),
        .txing         (txing)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input pool_pkg::uart_byte_t expected,
                              input pool_pkg::uart_byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_rx(input string name, input pool_pkg::uart_byte_s expected,
                            input pool_pkg::uart_byte_s actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic add_step(input step_op_e op, input logic [15:0] arg,
                            input pool_pkg::adc_sample_t mask, input logic rnd,
                            input logic report);
        step_s s;
        s.op     = op;
        s.rnd    = rnd;
        s.arg    = arg;
        s.mask   = mask;
        s.report = report;
        steps.push_back(s);
    endtask

    // each rx bit is held for one bit time starting on a rising edge
    task automatic drive_rx_bit(input logic level);
        rx <= level;
        repeat (pool_pkg::CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic send_uart_byte(input pool_pkg::uart_byte_t b);
        drive_rx_bit(1'b0);
        for (int i = 0; i < pool_pkg::BYTE_W; i++) begin
            drive_rx_bit(b[i]);
        end
        drive_rx_bit(1'b1);
    endtask

    // report format: tag, then prefix with low five bits, then prefix with high five
    task automatic push_report();
        exp_q.push_back(pool_pkg::TAG_BYTE);
        exp_q.push_back({pool_pkg::WORD_PREFIX, model_peak[4:0]});
        exp_q.push_back({pool_pkg::WORD_PREFIX, model_peak[9:5]});
    endtask

    // msb first, only bits with their mask bit set reach the register
    task automatic shift_sample(input pool_pkg::adc_sample_t value,
                                input pool_pkg::adc_sample_t mask);
        for (int i = pool_pkg::SAMPLE_W - 1; i >= 0; i--) begin
            adc_in        <= value[i];
            adc_bit_valid <= 1'b1;
            data_logging  <= mask[i];
            if (mask[i]) begin
                model_shift = {model_shift[pool_pkg::SAMPLE_W-2:0], value[i]};
            end
            @(posedge clk);
        end
        adc_bit_valid <= 1'b0;
        data_logging  <= 1'b0;
        data_ready    <= 1'b1;
        @(posedge clk);
        data_ready <= 1'b0;
        repeat (3) @(posedge clk);
        if (model_shift > model_peak) begin
            model_peak = model_shift;
        end
    endtask

    task automatic run_send(input pool_pkg::uart_byte_t b, input logic report);
        logic                 quiet;
        pool_pkg::uart_byte_s want;
        quiet      = (exp_q.size() == 0) && !report;
        want.valid = 1'b1;
        want.data  = b;
        send_uart_byte(b);
        for (int i = 0; i < FRAME_CYCLES && rx_q.size() == 0; i++) begin
            @(posedge clk);
        end
        if (rx_q.size() == 0) begin
            abort_run("no byte appeared on rx_byte after a uart frame");
        end
        check_rx("rx_byte", want, rx_q.pop_front());
        if (report) begin
            check_level("txing", 1'b1, txing);
            push_report();
        end else if (quiet) begin
            // line stays idle and no report starts
            repeat (FRAME_CYCLES) begin
                @(posedge clk);
                check_level("tx", 1'b1, tx);
                check_level("txing", 1'b0, txing);
            end
        end
    endtask

    // go past mid-window first so the next clear comes after any pending sample
    task automatic wait_window_start();
        @(posedge clk);
        while (run_cycles % WINDOW_CYCLES != WINDOW_CYCLES / 2) begin
            @(posedge clk);
        end
        while (run_cycles % WINDOW_CYCLES != 16) begin
            @(posedge clk);
        end
        model_peak = '0;
    endtask

    task automatic build_table();
        add_step(op_sync,  16'd0,    '0,       1'b0, 1'b0);
        // bytes other than the command only echo on rx_byte
        add_step(op_send,  16'h0055, '0,       1'b0, 1'b0);
        add_step(op_send,  16'h000d, '0,       1'b0, 1'b0);
        // running maximum, smaller later sample ignored
        add_step(op_shift, 16'h0123, ALL_BITS, 1'b0, 1'b0);
        add_step(op_shift, 16'h02c7, ALL_BITS, 1'b0, 1'b0);
        add_step(op_shift, 16'h00f0, ALL_BITS, 1'b0, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b1);
        // only four logged bits
        add_step(op_sync,  16'd0,    '0,       1'b0, 1'b0);
        add_step(op_shift, 16'h0000, ALL_BITS, 1'b0, 1'b0);
        add_step(op_shift, 16'h03ff, 10'h0f0,  1'b0, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b1);
        // idle past a whole window
        add_step(op_wait,  16'd1400, '0,       1'b0, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b1);
        add_step(op_sync,  16'd0,    '0,       1'b0, 1'b0);
        add_step(op_shift, 16'h0000, ALL_BITS, 1'b1, 1'b0);
        add_step(op_shift, 16'h0000, ALL_BITS, 1'b1, 1'b0);
        add_step(op_shift, 16'h0000, ALL_BITS, 1'b1, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b1);
        // sample and second command while the report runs
        add_step(op_shift, 16'h03fe, ALL_BITS, 1'b0, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b0);
        add_step(op_sync,  16'd0,    '0,       1'b0, 1'b0);
        add_step(op_shift, 16'h01a5, ALL_BITS, 1'b0, 1'b0);
        add_step(op_send,  CMD_R,    '0,       1'b0, 1'b1);
    endtask

    // cycle count since reset, also the window phase reference
    always @(posedge clk) begin
        if (reset) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
        if (run_cycles > timeout_limit) begin
            abort_run($sformatf("timeout, run did not finish in %0d cycles", timeout_limit));
        end
    end

    always @(posedge clk) begin
        if (!reset && rx_byte.valid) begin
            rx_q.push_back(rx_byte);
        end
    end

    // tx line monitor, samples each bit at its middle
    initial begin : tx_monitor
        pool_pkg::uart_byte_t got;
        forever begin
            @(posedge clk);
            if (!reset && tx == 1'b0) begin
                repeat (pool_pkg::CLKS_PER_BIT / 2) @(posedge clk);
                if (tx !== 1'b0) begin
                    abort_run("tx start bit ended before mid-bit");
                end
                for (int i = 0; i < pool_pkg::BYTE_W; i++) begin
                    repeat (pool_pkg::CLKS_PER_BIT) @(posedge clk);
                    got[i] = tx;
                end
                repeat (pool_pkg::CLKS_PER_BIT) @(posedge clk);
                if (tx !== 1'b1) begin
                    abort_run("tx frame has no stop bit");
                end
                if (exp_q.size() == 0) begin
                    abort_run("tx sent a byte that no report called for");
                end
                check_byte("tx byte", exp_q.pop_front(), got);
            end
        end
    end

    initial begin
        step_s                 step;
        pool_pkg::adc_sample_t value;
        logic [31:0]           rand_word;
        reset         <= 1'b1;
        adc_in        <= 1'b0;
        adc_bit_valid <= 1'b0;
        data_logging  <= 1'b0;
        data_ready    <= 1'b0;
        rx            <= 1'b1;
        seed        = 32'hde55_16f1;
        model_peak  = '0;
        model_shift = '0;
        build_table();
        timeout_limit = steps.size() * (4 * FRAME_CYCLES + WINDOW_CYCLES) + 4 * WINDOW_CYCLES;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[n]) begin
            step = steps[n];
            case (step.op)
                op_shift: begin
                    value = step.arg[pool_pkg::SAMPLE_W-1:0];
                    if (step.rnd) begin
                        rand_word = $random(seed);
                        value     = rand_word[pool_pkg::SAMPLE_W-1:0];
                    end
                    shift_sample(value, step.mask);
                end
                op_send: begin
                    run_send(step.arg[pool_pkg::BYTE_W-1:0], step.report);
                end
                op_wait: begin
                    repeat (step.arg) @(posedge clk);
                    // a full window passed, so a clear happened
                    if (int'(step.arg) > WINDOW_CYCLES) begin
                        model_peak = '0;
                    end
                end
                default: begin
                    wait_window_start();
                end
            endcase
        end
        // let the last report drain, then watch for stray frames
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        check_level("txing", 1'b0, txing);
        check_level("tx", 1'b1, tx);
        $display("Test completed successfully");
        $finish;
    end

endmodule
